//--- filelist.f
+incdir+.
usb_pkg.sv
ulpi_rx_frontend.sv
usb_crc_check.sv
usb_packet_decoder.sv
ulpi_decoder_top.sv
ulpi_decoder_assertions.sv
tb_clock_gen.sv
tb_ulpi_decoder.sv

//--- Makefile
TOP = tb_ulpi_decoder

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	elif ! grep -q "STATUS: PASS" sim.log; then \
	  echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- ulpi_vectors.txt
# outcome abort nbytes bytes(hex), first byte is the PID byte
# token CRC5 bits and data CRC16 bytes are filled in by the testbench
tok  0 3 E1 05 00
tok  0 3 69 2A 01
tok  0 3 2D 00 00
tok  0 3 B4 7F 07
sof  0 3 A5 34 02
sof  0 3 A5 FF 07
crc  0 3 A5 12 03
crc  0 3 E1 01 00
hsk  0 1 D2
hsk  0 1 5A
hsk  0 1 1E
none 0 1 D3
none 0 2 D2 00
data 0 5 C3 01 02 03 04
data 0 9 4B 10 20 30 40 50 60 70 80
data 0 1 C3
data 0 4 4B AA 55 0F
crc  0 4 C3 11 22 33
crc  1 4 4B 01 02 03
crc  1 2 E1 05

//--- tb_ulpi_decoder.sv
`default_nettype none

`include "ulpi_defines.svh"

module tb_ulpi_decoder;
  import usb_pkg::*;

  logic clock;
  logic reset;
  logic ulpi_dir;
  logic ulpi_nxt;
  byte_t ulpi_data;
  wire tok_valid;
  pid_t tok_pid;
  usb_addr_t tok_addr;
  usb_endp_t tok_endp;
  wire sof_valid;
  frame_t sof_frame;
  wire hsk_valid;
  pid_t hsk_pid;
  wire data_valid;
  byte_t data_byte;
  pid_t data_pid;
  wire data_end;
  wire crc_error;
  wire decode_idle;

  string vec_kind[$];
  int vec_abort[$];
  int vec_len[$];
  byte_t vec_bytes[$];
  byte_t pkt_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];
  logic [31:0] rng = 32'd13;
  int checks = 0;
  int errors = 0;
  int watch_cycles = 0;
  bit loaded = 0;
  bit busy_seen = 0;

  tb_clock_gen u_clock (.clock_o(clock), .reset_o(reset));

  ulpi_decoder_top DUT (
    .clock(clock), .reset(reset),
    .ulpi_dir_i(ulpi_dir), .ulpi_nxt_i(ulpi_nxt), .ulpi_data_i(ulpi_data),
    .tok_valid_o(tok_valid), .tok_pid_o(tok_pid), .tok_addr_o(tok_addr),
    .tok_endp_o(tok_endp), .sof_valid_o(sof_valid), .sof_frame_o(sof_frame),
    .hsk_valid_o(hsk_valid), .hsk_pid_o(hsk_pid), .data_valid_o(data_valid),
    .data_byte_o(data_byte), .data_pid_o(data_pid), .data_end_o(data_end),
    .crc_error_o(crc_error), .decode_idle_o(decode_idle)
  );

  bind usb_packet_decoder ulpi_decoder_assertions u_assertions (
    .clock(clock), .reset(reset), .state_i(state_q), .pkt_end_i(pkt_end_i),
    .tok_valid_i(tok_valid_o), .sof_valid_i(sof_valid_o), .hsk_valid_i(hsk_valid_o),
    .data_valid_i(data_valid_o), .data_end_i(data_end_o), .crc_error_i(crc_error_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Event word with the kind in the top nibble
  function automatic logic [31:0] make_event(input logic [3:0] kind, input logic [27:0] info);
    return {kind, info};
  endfunction

  // 1 token, 2 handshake, 3 data, 0 unknown
  function automatic int pid_class(input logic [3:0] pid);
    case (pid)
      `PID_OUT, `PID_IN, `PID_SOF, `PID_SETUP, `PID_PING: return 1;
      `PID_ACK, `PID_NAK, `PID_STALL: return 2;
      `PID_DATA0, `PID_DATA1: return 3;
      default: return 0;
    endcase
  endfunction

  // Inverted CRC5 placed so the first bit on the wire is the lowest
  function automatic logic [4:0] token_crc5(input logic [10:0] field);
    logic [4:0] r;
    logic [4:0] out;
    r = 5'b11111;
    for (int i = 0; i < 11; i++) begin
      if (r[4] != field[i]) begin
        r = {r[3:0], 1'b0} ^ 5'b00101;
      end else begin
        r = {r[3:0], 1'b0};
      end
    end
    r = ~r;
    for (int i = 0; i < 5; i++) out[i] = r[4 - i];
    return out;
  endfunction

  // CRC16 over the payload in pkt_q returned as {second byte, first byte}
  function automatic logic [15:0] payload_crc16();
    logic [15:0] r;
    logic [15:0] inv;
    logic [7:0] b;
    logic [7:0] lo;
    logic [7:0] hi;
    r = 16'hFFFF;
    for (int k = 1; k < pkt_q.size(); k++) begin
      b = pkt_q[k];
      for (int j = 0; j < 8; j++) begin
        if (r[15] != b[j]) begin
          r = {r[14:0], 1'b0} ^ 16'h8005;
        end else begin
          r = {r[14:0], 1'b0};
        end
      end
    end
    inv = ~r;
    for (int j = 0; j < 8; j++) begin
      lo[j] = inv[15 - j];
      hi[j] = inv[7 - j];
    end
    return {hi, lo};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic read_vectors(output bit ok);
    int fd;
    int code;
    string word;
    string rest;
    int abort;
    int len;
    byte_t b;
    ok = 0;
    fd = $fopen("ulpi_vectors.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", word);
      if (code != 1) break;
      if (word[0] == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%d %d", abort, len);
        vec_kind.push_back(word);
        vec_abort.push_back(abort);
        vec_len.push_back(len);
        for (int i = 0; i < len; i++) begin
          code = $fscanf(fd, "%h", b);
          vec_bytes.push_back(b);
        end
      end
    end
    $fclose(fd);
    ok = 1;
  endtask

  // Fill in CRC bytes and build the expected events
  task automatic prepare_packet(input int idx, input int offset);
    string kind;
    int cls;
    logic [10:0] field;
    logic [15:0] crc;
    byte_t p;
    byte_t b;
    kind = vec_kind[idx];
    field = '0;
    pkt_q.delete();
    exp_q.delete();
    for (int i = 0; i < vec_len[idx]; i++) pkt_q.push_back(vec_bytes[offset + i]);
    p = pkt_q[0];
    cls = pid_class(p[3:0]);
    if (cls == 1 && pkt_q.size() == 3 && vec_abort[idx] == 0) begin
      b = pkt_q[2];
      field = {b[2:0], pkt_q[1]};
      b[7:3] = (kind == "crc") ? ~token_crc5(field) : token_crc5(field);
      pkt_q[2] = b;
    end
    if (cls == 3 && vec_abort[idx] == 0) begin
      crc = payload_crc16();
      pkt_q.push_back(crc[7:0]);
      pkt_q.push_back(crc[15:8]);
      if (kind == "crc") pkt_q[1] = pkt_q[1] ^ 8'h01;
    end
    if (kind == "tok") begin
      exp_q.push_back(make_event(4'd1, 28'({p[3:0], field[6:0], field[10:7]})));
    end else if (kind == "sof") begin
      exp_q.push_back(make_event(4'd2, 28'(field)));
    end else if (kind == "hsk") begin
      exp_q.push_back(make_event(4'd3, 28'(p[3:0])));
    end else if (kind == "data" || (kind == "crc" && cls == 3)) begin
      // The last two bytes received are held back as CRC
      for (int i = 1; i < pkt_q.size() - 2; i++) begin
        exp_q.push_back(make_event(4'd4, 28'({p[3:0], pkt_q[i]})));
      end
      exp_q.push_back(make_event(4'd5, 28'(kind == "crc")));
    end else if (kind == "crc") begin
      exp_q.push_back(make_event(4'd6, 28'd0));
    end
  endtask

  task automatic drive_bus(input logic dir, input logic nxt, input byte_t data);
    @(posedge clock);
    #10;
    ulpi_dir = dir;
    ulpi_nxt = nxt;
    ulpi_data = data;
  endtask

  task automatic send_packet(input int abort);
    drive_bus(1'b1, 1'b0, 8'h00);
    drive_bus(1'b1, 1'b0, 8'h10);
    foreach (pkt_q[i]) begin
      rng = xorshift(rng);
      // Stall with RxActive still set
      while (rng[1:0] == 2'd0) begin
        drive_bus(1'b1, 1'b0, 8'h10);
        rng = xorshift(rng);
      end
      drive_bus(1'b1, 1'b1, pkt_q[i]);
    end
    if (abort == 0) drive_bus(1'b1, 1'b0, 8'h00);
    drive_bus(1'b0, 1'b0, 8'h00);
  endtask

  // Front end gets a bounded number of cycles to close the packet
  task automatic wait_idle();
    for (int i = 0; i < 20 && !decode_idle; i++) begin
      @(negedge clock);
    end
  endtask

  task automatic compare_packet(input string name);
    compare_value({name, "_events"}, exp_q.size(), act_q.size());
    for (int i = 0; i < exp_q.size() && i < act_q.size(); i++) begin
      compare_value($sformatf("%s_event%0d", name, i), exp_q[i], act_q[i]);
    end
    compare_value({name, "_busy"}, 1, 32'(busy_seen));
    compare_value({name, "_idle"}, 1, 32'(decode_idle));
    exp_q.delete();
    act_q.delete();
    busy_seen = 0;
  endtask

  // Strobes are sampled away from the active edge
  always @(negedge clock) begin
    if (!reset) begin
      if (!decode_idle) busy_seen = 1;
      if (tok_valid) act_q.push_back(make_event(4'd1, 28'({tok_pid, tok_addr, tok_endp})));
      if (sof_valid) act_q.push_back(make_event(4'd2, 28'(sof_frame)));
      if (hsk_valid) act_q.push_back(make_event(4'd3, 28'(hsk_pid)));
      if (data_valid) act_q.push_back(make_event(4'd4, 28'({data_pid, data_byte})));
      if (data_end) act_q.push_back(make_event(4'd5, 28'(crc_error)));
      else if (crc_error) act_q.push_back(make_event(4'd6, 28'd0));
    end
  end

  initial begin
    wait (loaded);
    repeat (watch_cycles) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", watch_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    bit ok;
    int offset;
    ulpi_dir = 1'b0;
    ulpi_nxt = 1'b0;
    ulpi_data = 8'h00;
    offset = 0;
    read_vectors(ok);
    if (!ok) begin
      $display("Could not open ulpi_vectors.txt");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      watch_cycles = vec_kind.size() * 200 + 1000;
      loaded = 1;
      wait (!reset);
      repeat (3) drive_bus(1'b0, 1'b0, 8'h00);
      for (int idx = 0; idx < vec_kind.size(); idx++) begin
        prepare_packet(idx, offset);
        offset += vec_len[idx];
        send_packet(vec_abort[idx]);
        wait_idle();
        repeat (4) @(posedge clock);
        compare_packet($sformatf("pkt%0d_%s", idx, vec_kind[idx]));
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    reset_o = 1'b1;
    repeat (5) @(posedge clock_o);
    #10 reset_o = 1'b0;
  end

  always #50 clock_o = ~clock_o;

endmodule

`default_nettype wire

//--- ulpi_decoder_assertions.sv
`default_nettype none

module ulpi_decoder_assertions (
  input wire                  clock,
  input wire                  reset,
  input usb_pkg::dec_state_t  state_i,
  input wire                  pkt_end_i,
  input wire                  tok_valid_i,
  input wire                  sof_valid_i,
  input wire                  hsk_valid_i,
  input wire                  data_valid_i,
  input wire                  data_end_i,
  input wire                  crc_error_i
);
  import usb_pkg::*;

  logic any_result;

  assign any_result = tok_valid_i || sof_valid_i || hsk_valid_i || data_end_i || crc_error_i;

  // A CRC error on a data packet rides along with data_end
  one_result: assert property (@(posedge clock) disable iff (reset)
    $onehot0({tok_valid_i, sof_valid_i, hsk_valid_i, data_end_i || crc_error_i}))
    else $error("More than one result strobe in a cycle");

  payload_in_data: assert property (@(posedge clock) disable iff (reset)
    data_valid_i |-> state_i == DATA)
    else $error("Payload byte outside the DATA state");

  result_after_end: assert property (@(posedge clock) disable iff (reset)
    any_result |-> $past(pkt_end_i))
    else $error("Result strobe without a packet end");

endmodule

`default_nettype wire

//--- ulpi_decoder_top.sv
`default_nettype none

`include "ulpi_defines.svh"

module ulpi_decoder_top (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    ulpi_dir_i,
  input  wire                    ulpi_nxt_i,
  input  wire usb_pkg::byte_t    ulpi_data_i,
  output wire                    tok_valid_o,
  output wire usb_pkg::pid_t     tok_pid_o,
  output wire usb_pkg::usb_addr_t tok_addr_o,
  output wire usb_pkg::usb_endp_t tok_endp_o,
  output wire                    sof_valid_o,
  output wire usb_pkg::frame_t   sof_frame_o,
  output wire                    hsk_valid_o,
  output wire usb_pkg::pid_t     hsk_pid_o,
  output wire                    data_valid_o,
  output wire usb_pkg::byte_t    data_byte_o,
  output wire usb_pkg::pid_t     data_pid_o,
  output wire                    data_end_o,
  output wire                    crc_error_o,
  output wire                    decode_idle_o
);
  import usb_pkg::*;

  logic   byte_valid;
  byte_t  byte_data;
  logic   pkt_start;
  logic   pkt_end;
  logic   field_valid;
  frame_t field_data;
  logic   crc5_ok;
  logic   crc16_ok;

  ulpi_rx_frontend u_frontend (
    .clock        (clock),
    .reset        (reset),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_i  (ulpi_data_i),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data),
    .pkt_start_o  (pkt_start),
    .pkt_end_o    (pkt_end),
    .idle_o       (decode_idle_o)
  );

  usb_crc_check u_crc (
    .clock         (clock),
    .reset         (reset),
    .byte_valid_i  (byte_valid),
    .byte_data_i   (byte_data),
    .pkt_start_i   (pkt_start),
    .field_valid_i (field_valid),
    .field_data_i  (field_data),
    .crc5_ok_o     (crc5_ok),
    .crc16_ok_o    (crc16_ok)
  );

  usb_packet_decoder u_decoder (
    .clock         (clock),
    .reset         (reset),
    .byte_valid_i  (byte_valid),
    .byte_data_i   (byte_data),
    .pkt_start_i   (pkt_start),
    .pkt_end_i     (pkt_end),
    .crc5_ok_i     (crc5_ok),
    .crc16_ok_i    (crc16_ok),
    .field_valid_o (field_valid),
    .field_data_o  (field_data),
    .tok_valid_o   (tok_valid_o),
    .tok_pid_o     (tok_pid_o),
    .tok_addr_o    (tok_addr_o),
    .tok_endp_o    (tok_endp_o),
    .sof_valid_o   (sof_valid_o),
    .sof_frame_o   (sof_frame_o),
    .hsk_valid_o   (hsk_valid_o),
    .hsk_pid_o     (hsk_pid_o),
    .data_valid_o  (data_valid_o),
    .data_byte_o   (data_byte_o),
    .data_pid_o    (data_pid_o),
    .data_end_o    (data_end_o),
    .crc_error_o   (crc_error_o)
  );

endmodule

`default_nettype wire

//--- usb_packet_decoder.sv
`default_nettype none

`include "ulpi_defines.svh"

module usb_packet_decoder (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 byte_valid_i,
  input  wire usb_pkg::byte_t byte_data_i,
  input  wire                 pkt_start_i,
  input  wire                 pkt_end_i,
  input  wire                 crc5_ok_i,
  input  wire                 crc16_ok_i,
  output logic                field_valid_o,
  output usb_pkg::frame_t     field_data_o,
  output logic                tok_valid_o,
  output usb_pkg::pid_t       tok_pid_o,
  output usb_pkg::usb_addr_t  tok_addr_o,
  output usb_pkg::usb_endp_t  tok_endp_o,
  output logic                sof_valid_o,
  output usb_pkg::frame_t     sof_frame_o,
  output logic                hsk_valid_o,
  output usb_pkg::pid_t       hsk_pid_o,
  output logic                data_valid_o,
  output usb_pkg::byte_t      data_byte_o,
  output usb_pkg::pid_t       data_pid_o,
  output logic                data_end_o,
  output logic                crc_error_o
);
  import usb_pkg::*;

  dec_state_t state_q;
  pid_t       pid_q;
  byte_t      tok_lo_q;
  frame_t     field_q;
  byte_t      hold0_q;
  byte_t      hold1_q;
  logic [1:0] fill_q;

  pid_t rx_pid;
  logic pid_ok;
  logic start_byte;
  logic next_byte;
  logic emit;

  function automatic dec_state_t pid_class(pid_t pid);
    case (pid)
      `PID_OUT, `PID_IN, `PID_SOF, `PID_SETUP, `PID_PING: return TOKEN_LO;
      `PID_ACK, `PID_NAK, `PID_STALL: return HANDSHAKE;
      `PID_DATA0, `PID_DATA1: return DATA;
      default: return DISCARD;
    endcase
  endfunction

  assign rx_pid     = byte_data_i[3:0];
  assign pid_ok     = rx_pid == ~byte_data_i[7:4];
  assign start_byte = byte_valid_i && pkt_start_i;
  assign next_byte  = byte_valid_i && !pkt_start_i;

  // Second token byte completes the field, CRC5 is judged in the same cycle
  assign field_valid_o = next_byte && state_q == TOKEN_HI;
  assign field_data_o  = {byte_data_i[2:0], tok_lo_q};

  // Payload leaves once two younger bytes are held behind it
  assign emit = next_byte && state_q == DATA && fill_q == 2'd2;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
    end else if (start_byte) begin
      state_q <= pid_ok ? pid_class(rx_pid) : DISCARD;
    end else if (pkt_end_i) begin
      state_q <= IDLE;
    end else if (next_byte) begin
      case (state_q)
        TOKEN_LO: state_q <= TOKEN_HI;
        TOKEN_HI: state_q <= TOKEN_CRC;
        // Too long for a token or handshake
        TOKEN_CRC, HANDSHAKE: state_q <= DISCARD;
        default: state_q <= state_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      fill_q <= 2'd0;
    end else if (start_byte) begin
      fill_q <= 2'd0;
    end else if (next_byte && state_q == DATA && fill_q != 2'd2) begin
      fill_q <= fill_q + 2'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (start_byte) begin
      pid_q <= rx_pid;
    end
    if (start_byte && pid_ok && pid_class(rx_pid) == DATA) begin
      data_pid_o <= rx_pid;
    end
    if (next_byte && state_q == TOKEN_LO) begin
      tok_lo_q <= byte_data_i;
    end
    if (field_valid_o) begin
      field_q <= field_data_o;
    end
    if (next_byte) begin
      hold0_q <= byte_data_i;
      hold1_q <= hold0_q;
    end
    if (emit) begin
      data_byte_o <= hold1_q;
    end
    if (pkt_end_i && state_q == TOKEN_CRC) begin
      tok_pid_o   <= pid_q;
      tok_addr_o  <= field_q[6:0];
      tok_endp_o  <= field_q[10:7];
      sof_frame_o <= field_q;
    end
    if (pkt_end_i && state_q == HANDSHAKE) begin
      hsk_pid_o <= pid_q;
    end
  end

  // One verdict per packet, the cycle after pkt_end
  always_ff @(posedge clock) begin
    if (reset) begin
      data_valid_o <= 1'b0;
      tok_valid_o  <= 1'b0;
      sof_valid_o  <= 1'b0;
      hsk_valid_o  <= 1'b0;
      data_end_o   <= 1'b0;
      crc_error_o  <= 1'b0;
    end else begin
      data_valid_o <= emit;
      tok_valid_o  <= 1'b0;
      sof_valid_o  <= 1'b0;
      hsk_valid_o  <= 1'b0;
      data_end_o   <= 1'b0;
      crc_error_o  <= 1'b0;
      if (pkt_end_i) begin
        case (state_q)
          TOKEN_CRC: begin
            if (!crc5_ok_i) begin
              crc_error_o <= 1'b1;
            end else if (pid_q == `PID_SOF) begin
              sof_valid_o <= 1'b1;
            end else begin
              tok_valid_o <= 1'b1;
            end
          end
          // Token cut short
          TOKEN_LO, TOKEN_HI: crc_error_o <= 1'b1;
          HANDSHAKE: hsk_valid_o <= 1'b1;
          DATA: begin
            data_end_o  <= 1'b1;
            crc_error_o <= !crc16_ok_i;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- usb_crc_check.sv
`default_nettype none

`include "ulpi_defines.svh"

module usb_crc_check (
  input  wire                  clock,
  input  wire                  reset,
  input  wire                  byte_valid_i,
  input  wire usb_pkg::byte_t  byte_data_i,
  input  wire                  pkt_start_i,
  input  wire                  field_valid_i,
  input  wire usb_pkg::frame_t field_data_i,
  output logic                 crc5_ok_o,
  output logic                 crc16_ok_o
);
  import usb_pkg::*;

  crc16_t crc16_q;
  crc5_t  crc5_q;
  byte_t  last_q;

  // Bits go in LSB first, polynomial x^16 + x^15 + x^2 + 1
  function automatic crc16_t crc16_next(crc16_t crc, byte_t data);
    crc16_t c;
    logic   fb;
    integer i;
    c = crc;
    for (i = 0; i < 8; i = i + 1) begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ 16'h8005;
      end
    end
    return c;
  endfunction

  // Polynomial x^5 + x^2 + 1 over the 11 field bits
  function automatic crc5_t crc5_token(frame_t field);
    crc5_t  c;
    logic   fb;
    integer i;
    c = `CRC5_INIT;
    for (i = 0; i < 11; i = i + 1) begin
      fb = c[4] ^ field[i];
      c  = {c[3:0], 1'b0};
      if (fb) begin
        c = c ^ 5'h05;
      end
    end
    // Sent inverted and high bit first, so it sits bit-reversed in the byte
    return ~{c[0], c[1], c[2], c[3], c[4]};
  endfunction

  // PID byte only restarts the register, it is not covered
  always_ff @(posedge clock) begin
    if (reset) begin
      crc16_q <= `CRC16_INIT;
    end else if (byte_valid_i) begin
      crc16_q <= pkt_start_i ? `CRC16_INIT : crc16_next(crc16_q, byte_data_i);
    end
  end

  always_ff @(posedge clock) begin
    if (byte_valid_i) begin
      last_q <= byte_data_i;
    end
    if (field_valid_i) begin
      crc5_q <= crc5_token(field_data_i);
    end
  end

  assign crc16_ok_o = crc16_q == `CRC16_RESIDUE;
  assign crc5_ok_o  = crc5_q == last_q[7:3];

endmodule

`default_nettype wire

//--- ulpi_rx_frontend.sv
`default_nettype none

`include "ulpi_defines.svh"

module ulpi_rx_frontend (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 ulpi_dir_i,
  input  wire                 ulpi_nxt_i,
  input  wire usb_pkg::byte_t ulpi_data_i,
  output logic                byte_valid_o,
  output usb_pkg::byte_t      byte_data_o,
  output logic                pkt_start_o,
  output logic                pkt_end_o,
  output logic                idle_o
);
  import usb_pkg::*;

  logic  dir_q;
  logic  dir_prev_q;
  logic  nxt_q;
  byte_t data_q;
  logic  in_pkt_q;

  logic turnaround;
  logic pkt_byte;
  logic rx_cmd;
  logic end_cond;

  // Input stage for the PHY pins
  always_ff @(posedge clock) begin
    data_q <= ulpi_data_i;
    if (reset) begin
      dir_q      <= 1'b0;
      dir_prev_q <= 1'b0;
      nxt_q      <= 1'b0;
    end else begin
      dir_q      <= ulpi_dir_i;
      dir_prev_q <= dir_q;
      nxt_q      <= ulpi_nxt_i;
    end
  end

  // PHY takes the bus, nothing valid on data this cycle
  assign turnaround = dir_q && !dir_prev_q;

  assign pkt_byte = dir_q && nxt_q && !turnaround;
  assign rx_cmd   = dir_q && !nxt_q && !turnaround;

  // RxActive dropped, or the PHY released the bus mid-packet
  assign end_cond = in_pkt_q && ((rx_cmd && data_q[5:4] != `RXCMD_ACTIVE) || !dir_q);

  always_ff @(posedge clock) begin
    byte_data_o <= data_q;
    if (reset) begin
      byte_valid_o <= 1'b0;
      pkt_start_o  <= 1'b0;
      pkt_end_o    <= 1'b0;
      in_pkt_q     <= 1'b0;
    end else begin
      byte_valid_o <= pkt_byte;
      pkt_start_o  <= pkt_byte && !in_pkt_q;
      pkt_end_o    <= end_cond;
      if (end_cond) begin
        in_pkt_q <= 1'b0;
      end else if (pkt_byte) begin
        in_pkt_q <= 1'b1;
      end
    end
  end

  assign idle_o = !in_pkt_q;

endmodule

`default_nettype wire

//--- usb_pkg.sv
`default_nettype none

package usb_pkg;

  // One byte on the ULPI data lines
  typedef logic [7:0] byte_t;

  // PID code, lower nibble of the first packet byte
  typedef logic [3:0] pid_t;

  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;

  // Frame number, also the width of the token field
  typedef logic [10:0] frame_t;

  typedef logic [4:0] crc5_t;
  typedef logic [15:0] crc16_t;

  // Packet decoder states
  typedef enum logic [2:0] {
    IDLE,
    // Waiting for the first token byte
    TOKEN_LO,
    // Waiting for the byte with field bits 10:8 and the CRC5
    TOKEN_HI,
    // Token complete, only the end may follow
    TOKEN_CRC,
    HANDSHAKE,
    DATA,
    // Bad PID or bad length, wait for the end quietly
    DISCARD
  } dec_state_t;

endpackage

`default_nettype wire

//--- ulpi_defines.svh
`ifndef ULPI_DEFINES_SVH
`define ULPI_DEFINES_SVH

// Token PIDs
`define PID_OUT   4'b0001
`define PID_IN    4'b1001
`define PID_SOF   4'b0101
`define PID_SETUP 4'b1101
`define PID_PING  4'b0100

// Handshake PIDs
`define PID_ACK   4'b0010
`define PID_NAK   4'b1010
`define PID_STALL 4'b1110

// Data PIDs
`define PID_DATA0 4'b0011
`define PID_DATA1 4'b1011

// RX_CMD bits 5:4 while the PHY is receiving
`define RXCMD_ACTIVE 2'b01

`define CRC16_RESIDUE 16'h800D
`define CRC5_INIT     5'h1F
`define CRC16_INIT    16'hFFFF

`endif
